/* Bender.yml */
package:
  name: tpu_lite

sources:
  - src/tpu_pkg.sv
  - src/axi_lite_regs.sv
  - src/tpu_ctrl.sv
  - src/conv_unit.sv
  - src/activation_unit.sv
  - src/tpu_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_tpu.sv

/* src/activation_unit.sv */
`timescale 1ns/1ns

module activation_unit import tpu_pkg::*; (
	input  logic                           aclk,
	input  logic                           rst_i,
	input  logic                           valid_i,
	input  logic                           relu_i,
	input  logic [B_SLOT-1:0]              slot_i,
	input  logic [N_KERNEL-1:0][B_ACC-1:0] acc_i,
	output logic                           res_we_o,
	output logic [B_SLOT-1:0]              res_slot_o,
	output logic [N_KERNEL-1:0][B_RES-1:0] res_data_o
);

	logic [N_KERNEL-1:0][B_RES-1:0] act;
	logic signed [B_ACC-1:0]        val;

	always_comb begin
		act = '0;
		val = '0;
		for (int k = 0; k < N_KERNEL; k++) begin
			val = $signed(acc_i[k]);
			// relu first, then clip.
			if (relu_i && val < 0) begin
				val = '0;
			end
			if (val > RES_MAX) begin
				act[k] = RES_MAX[B_RES-1:0];
			end else if (val < RES_MIN) begin
				act[k] = RES_MIN[B_RES-1:0];
			end else begin
				act[k] = val[B_RES-1:0];
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			res_we_o <= 1'b0;
		end else begin
			res_we_o <= valid_i;
		end
	end

	always_ff @(posedge aclk) begin
		if (valid_i) begin
			res_slot_o <= slot_i;
			res_data_o <= act;
		end
	end

endmodule

/* src/axi_lite_regs.sv */
`timescale 1ns/1ns

module axi_lite_regs import tpu_pkg::*; (
	input  logic                           aclk,
	input  logic                           rst_i,

	input  logic [AXI_AW-1:0]              s_axi_awaddr_i,
	input  logic                           s_axi_awvalid_i,
	output logic                           s_axi_awready_o,
	input  logic [AXI_DW-1:0]              s_axi_wdata_i,
	input  logic [AXI_DW/8-1:0]            s_axi_wstrb_i,
	input  logic                           s_axi_wvalid_i,
	output logic                           s_axi_wready_o,
	output logic [1:0]                     s_axi_bresp_o,
	output logic                           s_axi_bvalid_o,
	input  logic                           s_axi_bready_i,
	input  logic [AXI_AW-1:0]              s_axi_araddr_i,
	input  logic                           s_axi_arvalid_i,
	output logic                           s_axi_arready_o,
	output logic [AXI_DW-1:0]              s_axi_rdata_o,
	output logic [1:0]                     s_axi_rresp_o,
	output logic                           s_axi_rvalid_o,
	input  logic                           s_axi_rready_i,

	output logic                           start_o,
	input  logic                           busy_i,
	input  logic                           done_i,

	input  logic                           res_we_i,
	input  logic [B_SLOT-1:0]              res_slot_i,
	input  logic [N_KERNEL-1:0][B_RES-1:0] res_data_i
);

	logic                                        wr_fire;
	logic [N_SLOT-1:0][N_KERNEL-1:0][B_RES-1:0] res_bank;
	logic [N_KERNEL*B_RES-1:0]                   rd_slot_bits;
	logic [AXI_DW-1:0]                           rd_word;

	// address and data are taken together, one beat per response.
	assign s_axi_awready_o = wr_fire;
	assign s_axi_wready_o  = wr_fire;
	assign s_axi_bresp_o   = AXI_OKAY;
	assign s_axi_arready_o = !s_axi_rvalid_o;
	assign s_axi_rresp_o   = AXI_OKAY;

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			wr_fire        <= 1'b0;
			s_axi_bvalid_o <= 1'b0;
			start_o        <= 1'b0;
		end else begin
			wr_fire <= s_axi_awvalid_i && s_axi_wvalid_i && !s_axi_bvalid_o && !wr_fire;
			if (wr_fire) begin
				s_axi_bvalid_o <= 1'b1;
			end else if (s_axi_bready_i) begin
				s_axi_bvalid_o <= 1'b0;
			end
			// only bit 0 of the control word matters.
			start_o <= wr_fire && (s_axi_awaddr_i[AXI_AW-1:2] == REG_CTRL[AXI_AW-1:2])
				&& s_axi_wstrb_i[0] && s_axi_wdata_i[0];
		end
	end

	// result bank, one row of kernels per slot.
	always_ff @(posedge aclk) begin
		if (rst_i) begin
			res_bank <= '0;
		end else if (res_we_i) begin
			res_bank[res_slot_i] <= res_data_i;
		end
	end

	assign rd_slot_bits = res_bank[s_axi_araddr_i[B_SLOT+2:3]];

	always_comb begin
		rd_word = '0;
		if (s_axi_araddr_i[AXI_AW-1:2] == REG_STATUS[AXI_AW-1:2]) begin
			rd_word = {{(AXI_DW-2){1'b0}}, done_i, busy_i};
		end else if (s_axi_araddr_i[AXI_AW-1:B_SLOT+3] == REG_RES_BASE[AXI_AW-1:B_SLOT+3]) begin
			// word 0 holds kernels 0 and 1, word 1 kernels 2 and 3.
			rd_word = rd_slot_bits[AXI_DW*s_axi_araddr_i[2] +: AXI_DW];
		end
	end

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			s_axi_rvalid_o <= 1'b0;
		end else if (s_axi_arvalid_i && s_axi_arready_o) begin
			s_axi_rvalid_o <= 1'b1;
		end else if (s_axi_rready_i) begin
			s_axi_rvalid_o <= 1'b0;
		end
	end

	// read data is captured once per address beat.
	always_ff @(posedge aclk) begin
		if (s_axi_arvalid_i && s_axi_arready_o) begin
			s_axi_rdata_o <= rd_word;
		end
	end

	// a write response is never withdrawn before the master takes it.
	a_bvalid_hold: assert property (@(posedge aclk) disable iff (rst_i)
		s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o);

	// read data holds while the master stalls, even as results land in the bank.
	a_rdata_stable: assert property (@(posedge aclk) disable iff (rst_i)
		s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o && $stable(s_axi_rdata_o));

endmodule

/* src/conv_unit.sv */
`timescale 1ns/1ns

module conv_unit import tpu_pkg::*; #(
	parameter int UNIT_IDX = 0
) (
	input  logic                                aclk,
	input  logic                                rst_i,
	input  logic                                wgt_we_i,
	input  logic [N_KERNEL-1:0][B_PIXEL-1:0]    wgt_data_i,
	input  logic                                valid_i,
	input  logic                                relu_i,
	input  logic [B_SLOT-1:0]                   slot_i,
	input  logic [N_CONV_UNIT-1:0][B_PIXEL-1:0] pix_i,
	input  logic [N_KERNEL-1:0][B_ACC-1:0]      acc_i,
	output logic                                valid_o,
	output logic                                relu_o,
	output logic [B_SLOT-1:0]                   slot_o,
	output logic [N_CONV_UNIT-1:0][B_PIXEL-1:0] pix_o,
	output logic [N_KERNEL-1:0][B_ACC-1:0]      acc_o
);

	// one signed weight per kernel for this channel.
	logic [N_KERNEL-1:0][B_PIXEL-1:0] wgt_q;

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			wgt_q <= '0;
		end else if (wgt_we_i) begin
			wgt_q <= wgt_data_i;
		end
	end

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	// partial sums grow by this channel's products.
	always_ff @(posedge aclk) begin
		if (valid_i) begin
			relu_o <= relu_i;
			slot_o <= slot_i;
			pix_o  <= pix_i;
			for (int k = 0; k < N_KERNEL; k++) begin
				acc_o[k] <= $signed(acc_i[k])
					+ $signed(pix_i[UNIT_IDX]) * $signed(wgt_q[k]);
			end
		end
	end

endmodule

/* src/tpu_ctrl.sv */
`timescale 1ns/1ns

module tpu_ctrl import tpu_pkg::*; (
	input  logic                                aclk,
	input  logic                                rst_i,
	input  logic                                start_i,
	output logic                                busy_o,
	output logic                                done_o,
	output logic [PMEM_N-1:0]                   pmem_addr_o,
	input  logic [INST_W-1:0]                   pmem_do_i,
	output logic [N_CONV_UNIT-1:0]              wgt_we_o,
	output logic [N_KERNEL-1:0][B_PIXEL-1:0]    wgt_data_o,
	output logic                                conv_valid_o,
	output logic                                conv_relu_o,
	output logic [B_SLOT-1:0]                   conv_slot_o,
	output logic [N_CONV_UNIT-1:0][B_PIXEL-1:0] conv_pix_o
);

	logic [1:0]          state;
	logic [PMEM_N-1:0]   pc;
	logic                fetch_vld;
	logic [B_UNIT-1:0]   wgt_unit;
	logic [B_FLIGHT-1:0] flight_cnt;
	logic [RES_LAT-1:0]  flight_pipe;
	tpu_inst_u           inst;
	logic                dec_vld;
	logic                issue_conv;
	logic                stop_fetch;
	logic                wgt_go;
	logic                retire;

	assign inst       = pmem_do_i;
	assign dec_vld    = (state == ST_FETCH) && fetch_vld;
	assign issue_conv = dec_vld && (inst.conv.opcode == OP_CONV);
	assign stop_fetch = dec_vld && (inst.wgt.opcode == OP_WGT || inst.wgt.opcode == OP_END);
	assign wgt_go     = (state == ST_HOLD) && (flight_cnt == '0);
	assign retire     = flight_pipe[RES_LAT-1];

	assign pmem_addr_o = pc;
	assign busy_o      = (state != ST_IDLE);
	assign wgt_we_o    = wgt_go ? (N_CONV_UNIT'(1) << wgt_unit) : '0;

	// a vector counts until the result bank has taken it.
	always_ff @(posedge aclk) begin
		if (rst_i) begin
			flight_cnt  <= '0;
			flight_pipe <= '0;
		end else begin
			flight_pipe <= {flight_pipe[RES_LAT-2:0], conv_valid_o};
			if (issue_conv && !retire) begin
				flight_cnt <= flight_cnt + 1'b1;
			end else if (retire && !issue_conv) begin
				flight_cnt <= flight_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			state        <= ST_IDLE;
			pc           <= '0;
			fetch_vld    <= 1'b0;
			done_o       <= 1'b0;
			conv_valid_o <= 1'b0;
		end else begin
			conv_valid_o <= issue_conv;
			case (state)
				ST_IDLE: begin
					if (start_i) begin
						state     <= ST_FETCH;
						pc        <= '0;
						fetch_vld <= 1'b0;
						done_o    <= 1'b0;
					end
				end
				ST_FETCH: begin
					// on a stop the word read behind it is dropped and fetched again.
					fetch_vld <= !stop_fetch;
					if (!stop_fetch) begin
						pc <= pc + 1'b1;
					end else begin
						state <= (inst.wgt.opcode == OP_WGT) ? ST_HOLD : ST_DRAIN;
					end
				end
				ST_HOLD: begin
					if (wgt_go) begin
						state <= ST_FETCH;
					end
				end
				default: begin
					if (flight_cnt == '0) begin
						state  <= ST_IDLE;
						done_o <= 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (issue_conv) begin
			conv_relu_o <= inst.conv.relu;
			conv_slot_o <= inst.conv.slot;
			conv_pix_o  <= inst.conv.pix;
		end
		if (dec_vld && inst.wgt.opcode == OP_WGT) begin
			wgt_unit   <= inst.wgt.unit;
			wgt_data_o <= inst.wgt.wgt;
		end
	end

	// weights change only on one unit, and only with the chain empty.
	a_wgt_quiet: assert property (@(posedge aclk) disable iff (rst_i)
		wgt_we_o != '0 |-> $onehot(wgt_we_o) && !conv_valid_o && flight_pipe == '0);

endmodule

/* src/tpu_pkg.sv */
package tpu_pkg;

	// datapath sizes.
	localparam int N_CONV_UNIT = 4;
	localparam int N_KERNEL    = 4;
	localparam int B_PIXEL     = 8;
	localparam int B_ACC       = 18;
	localparam int B_RES       = 16;
	localparam int N_SLOT      = 8;
	localparam int B_SLOT      = 3;
	localparam int B_UNIT      = 2;
	localparam int PMEM_N      = 8;
	localparam int INST_W      = 64;

	// cycles from chain issue until the result bank holds the vector.
	localparam int RES_LAT  = N_CONV_UNIT + 1;
	localparam int B_FLIGHT = $clog2(N_CONV_UNIT + 3);

	// signed result range after activation.
	localparam logic signed [B_ACC-1:0] RES_MAX = B_ACC'(2 ** (B_RES - 1) - 1);
	localparam logic signed [B_ACC-1:0] RES_MIN = B_ACC'(-(2 ** (B_RES - 1)));

	localparam logic [3:0] OP_END  = 4'd0;
	localparam logic [3:0] OP_WGT  = 4'd1;
	localparam logic [3:0] OP_CONV = 4'd2;

	// AXI4-Lite register map.
	localparam int         AXI_AW       = 8;
	localparam int         AXI_DW       = 32;
	localparam logic [1:0] AXI_OKAY     = 2'b00;
	localparam logic [7:0] REG_CTRL     = 8'h00;
	localparam logic [7:0] REG_STATUS   = 8'h04;
	localparam logic [7:0] REG_RES_BASE = 8'h40;

	// controller states.
	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_FETCH = 2'd1;
	localparam logic [1:0] ST_HOLD  = 2'd2;
	localparam logic [1:0] ST_DRAIN = 2'd3;

	// one program word, read as a weight load or as a pixel vector.
	typedef union packed {
		struct packed {
			logic [3:0]                       opcode;
			logic [1:0]                       rsvd0;
			logic [B_UNIT-1:0]                unit;
			logic [23:0]                      rsvd1;
			logic [N_KERNEL-1:0][B_PIXEL-1:0] wgt;
		} wgt;
		struct packed {
			logic [3:0]                          opcode;
			logic [6:0]                          rsvd0;
			logic                                relu;
			logic                                rsvd1;
			logic [B_SLOT-1:0]                   slot;
			logic [15:0]                         rsvd2;
			logic [N_CONV_UNIT-1:0][B_PIXEL-1:0] pix;
		} conv;
	} tpu_inst_u;

endpackage

/* src/tpu_top.sv */
`timescale 1ns/1ns

module tpu_top import tpu_pkg::*; (
	input  logic                aclk,
	input  logic                rst_i,

	input  logic [AXI_AW-1:0]   s_axi_awaddr_i,
	input  logic                s_axi_awvalid_i,
	output logic                s_axi_awready_o,
	input  logic [AXI_DW-1:0]   s_axi_wdata_i,
	input  logic [AXI_DW/8-1:0] s_axi_wstrb_i,
	input  logic                s_axi_wvalid_i,
	output logic                s_axi_wready_o,
	output logic [1:0]          s_axi_bresp_o,
	output logic                s_axi_bvalid_o,
	input  logic                s_axi_bready_i,
	input  logic [AXI_AW-1:0]   s_axi_araddr_i,
	input  logic                s_axi_arvalid_i,
	output logic                s_axi_arready_o,
	output logic [AXI_DW-1:0]   s_axi_rdata_o,
	output logic [1:0]          s_axi_rresp_o,
	output logic                s_axi_rvalid_o,
	input  logic                s_axi_rready_i,

	output logic [PMEM_N-1:0]   pmem_addr_o,
	input  logic [INST_W-1:0]   pmem_do_i
);

	logic                                start;
	logic                                busy;
	logic                                done;
	logic [N_CONV_UNIT-1:0]              wgt_we;
	logic [N_KERNEL-1:0][B_PIXEL-1:0]    wgt_data;
	logic                                res_we;
	logic [B_SLOT-1:0]                   res_slot;
	logic [N_KERNEL-1:0][B_RES-1:0]      res_data;

	// chain links, index i feeds conv unit i.
	logic                                valid_c [N_CONV_UNIT+1];
	logic                                relu_c  [N_CONV_UNIT+1];
	logic [B_SLOT-1:0]                   slot_c  [N_CONV_UNIT+1];
	logic [N_CONV_UNIT-1:0][B_PIXEL-1:0] pix_c   [N_CONV_UNIT+1];
	logic [N_KERNEL-1:0][B_ACC-1:0]      acc_c   [N_CONV_UNIT+1];

	assign acc_c[0] = '0;

	axi_lite_regs axi_lite_regs_i (
		.aclk            (aclk),
		.rst_i           (rst_i),
		.s_axi_awaddr_i  (s_axi_awaddr_i),
		.s_axi_awvalid_i (s_axi_awvalid_i),
		.s_axi_awready_o (s_axi_awready_o),
		.s_axi_wdata_i   (s_axi_wdata_i),
		.s_axi_wstrb_i   (s_axi_wstrb_i),
		.s_axi_wvalid_i  (s_axi_wvalid_i),
		.s_axi_wready_o  (s_axi_wready_o),
		.s_axi_bresp_o   (s_axi_bresp_o),
		.s_axi_bvalid_o  (s_axi_bvalid_o),
		.s_axi_bready_i  (s_axi_bready_i),
		.s_axi_araddr_i  (s_axi_araddr_i),
		.s_axi_arvalid_i (s_axi_arvalid_i),
		.s_axi_arready_o (s_axi_arready_o),
		.s_axi_rdata_o   (s_axi_rdata_o),
		.s_axi_rresp_o   (s_axi_rresp_o),
		.s_axi_rvalid_o  (s_axi_rvalid_o),
		.s_axi_rready_i  (s_axi_rready_i),
		.start_o         (start),
		.busy_i          (busy),
		.done_i          (done),
		.res_we_i        (res_we),
		.res_slot_i      (res_slot),
		.res_data_i      (res_data)
	);

	tpu_ctrl tpu_ctrl_i (
		.aclk         (aclk),
		.rst_i        (rst_i),
		.start_i      (start),
		.busy_o       (busy),
		.done_o       (done),
		.pmem_addr_o  (pmem_addr_o),
		.pmem_do_i    (pmem_do_i),
		.wgt_we_o     (wgt_we),
		.wgt_data_o   (wgt_data),
		.conv_valid_o (valid_c[0]),
		.conv_relu_o  (relu_c[0]),
		.conv_slot_o  (slot_c[0]),
		.conv_pix_o   (pix_c[0])
	);

	for (genvar i = 0; i < N_CONV_UNIT; i++) begin : g_conv
		conv_unit #(
			.UNIT_IDX (i)
		) conv_unit_i (
			.aclk       (aclk),
			.rst_i      (rst_i),
			.wgt_we_i   (wgt_we[i]),
			.wgt_data_i (wgt_data),
			.valid_i    (valid_c[i]),
			.relu_i     (relu_c[i]),
			.slot_i     (slot_c[i]),
			.pix_i      (pix_c[i]),
			.acc_i      (acc_c[i]),
			.valid_o    (valid_c[i+1]),
			.relu_o     (relu_c[i+1]),
			.slot_o     (slot_c[i+1]),
			.pix_o      (pix_c[i+1]),
			.acc_o      (acc_c[i+1])
		);
	end

	activation_unit activation_unit_i (
		.aclk       (aclk),
		.rst_i      (rst_i),
		.valid_i    (valid_c[N_CONV_UNIT]),
		.relu_i     (relu_c[N_CONV_UNIT]),
		.slot_i     (slot_c[N_CONV_UNIT]),
		.acc_i      (acc_c[N_CONV_UNIT]),
		.res_we_o   (res_we),
		.res_slot_o (res_slot),
		.res_data_o (res_data)
	);

endmodule

/* verif/tb_axi_tasks.svh */
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

// random value in 0 .. n-1 from the shared seed.
function automatic int unsigned pick(input int unsigned n);
	return $unsigned($random(seed)) % n;
endfunction

// one write beat, then bready held low for a random number of cycles.
task automatic write_reg(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data);
	int unsigned hold;
	hold = pick(HOLD_MAX);
	s_axi_awaddr_i = addr;
	s_axi_awvalid_i = 1'b1;
	s_axi_wdata_i = data;
	s_axi_wstrb_i = '1;
	s_axi_wvalid_i = 1'b1;
	do begin
		@(negedge aclk);
	end while (!(s_axi_awready_o && s_axi_wready_o));
	@(posedge aclk);
	#1;
	s_axi_awvalid_i = 1'b0;
	s_axi_wvalid_i = 1'b0;
	repeat (hold) begin
		@(posedge aclk);
		#1;
	end
	assert (s_axi_bvalid_o) else stop_with("no write response after the address handshake");
	s_axi_bready_i = 1'b1;
	@(posedge aclk);
	#1;
	s_axi_bready_i = 1'b0;
endtask

// one read beat, rready held low for a random number of cycles.
task automatic read_reg(input logic [AXI_AW-1:0] addr, output logic [AXI_DW-1:0] data);
	int unsigned hold;
	hold = pick(HOLD_MAX);
	s_axi_araddr_i = addr;
	s_axi_arvalid_i = 1'b1;
	do begin
		@(negedge aclk);
	end while (!s_axi_arready_o);
	@(posedge aclk);
	#1;
	s_axi_arvalid_i = 1'b0;
	repeat (hold) begin
		@(posedge aclk);
		#1;
	end
	assert (s_axi_rvalid_o) else stop_with("no read response after the address handshake");
	data = s_axi_rdata_o;
	s_axi_rready_i = 1'b1;
	@(posedge aclk);
	#1;
	s_axi_rready_i = 1'b0;
endtask

`endif

/* verif/tb_tpu.sv */
`timescale 1ns/1ns

module tb_tpu import tpu_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int HOLD_MAX   = 8;
	// 5 programs of at most 64 words, drains and polled AXI reads, with margin.
	localparam int CYCLE_LIMIT = 20000;

	logic                aclk;
	logic                rst_i;
	logic [AXI_AW-1:0]   s_axi_awaddr_i;
	logic                s_axi_awvalid_i;
	logic                s_axi_awready_o;
	logic [AXI_DW-1:0]   s_axi_wdata_i;
	logic [AXI_DW/8-1:0] s_axi_wstrb_i;
	logic                s_axi_wvalid_i;
	logic                s_axi_wready_o;
	logic [1:0]          s_axi_bresp_o;
	logic                s_axi_bvalid_o;
	logic                s_axi_bready_i;
	logic [AXI_AW-1:0]   s_axi_araddr_i;
	logic                s_axi_arvalid_i;
	logic                s_axi_arready_o;
	logic [AXI_DW-1:0]   s_axi_rdata_o;
	logic [1:0]          s_axi_rresp_o;
	logic                s_axi_rvalid_o;
	logic                s_axi_rready_i;
	logic [PMEM_N-1:0]   pmem_addr_o;
	logic [INST_W-1:0]   pmem_do_i;

	logic [INST_W-1:0]  pmem [2 ** PMEM_N];
	logic [B_PIXEL-1:0] wgt_model [N_CONV_UNIT][N_KERNEL];
	logic [B_RES-1:0]   exp_res [N_SLOT][N_KERNEL];
	int                 prog_len = 0;
	int                 cycle_cnt = 0;
	integer             seed;

	tpu_top uut (.*);

	initial begin
		aclk = 1'b0;
		forever #(CLK_PERIOD / 2) aclk = ~aclk;
	end

	// synchronous program memory, one cycle of read latency.
	always @(posedge aclk) begin
		pmem_do_i <= #1 pmem[pmem_addr_o];
	end

	always @(posedge aclk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT) begin
			stop_with($sformatf("timeout: test did not end within %0d cycles", CYCLE_LIMIT));
		end
	end

	task automatic stop_with(input string line);
		$display("%s", line);
		$display("Checks failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic value_error(input string msg);
		stop_with($sformatf("FAILED at %0t ns: %s", $time, msg));
	endtask

	`include "tb_axi_tasks.svh"

	a_bvalid_hold: assert property (@(posedge aclk) disable iff (rst_i)
		s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o)
		else value_error("bvalid dropped before bready");

	a_rdata_hold: assert property (@(posedge aclk) disable iff (rst_i)
		s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o && $stable(s_axi_rdata_o))
		else value_error("rvalid or rdata changed while rready was low");

	a_bresp_okay: assert property (@(posedge aclk) disable iff (rst_i)
		s_axi_bvalid_o |-> s_axi_bresp_o == AXI_OKAY)
		else value_error($sformatf("bresp %0d, expected OKAY", s_axi_bresp_o));

	a_rresp_okay: assert property (@(posedge aclk) disable iff (rst_i)
		s_axi_rvalid_o |-> s_axi_rresp_o == AXI_OKAY)
		else value_error($sformatf("rresp %0d, expected OKAY", s_axi_rresp_o));

	task automatic clear_program();
		for (int a = 0; a < 2 ** PMEM_N; a++) begin
			// unused words carry a skipped opcode and their own address.
			pmem[a] = {4'hf, 20'h0, 8'(a), 24'h0, 8'(a) ^ 8'h5a};
		end
		prog_len = 0;
	endtask

	task automatic add_weight_load(input int unit, input logic [31:0] w);
		logic [INST_W-1:0] word;
		word = '0;
		word[63:60] = OP_WGT;
		word[57:56] = unit[1:0];
		word[31:0] = w;
		pmem[prog_len] = word;
		prog_len++;
		for (int k = 0; k < N_KERNEL; k++) begin
			wgt_model[unit][k] = w[8*k +: 8];
		end
	endtask

	task automatic push_conv(input int slot, input bit relu, input logic [31:0] pix);
		logic [INST_W-1:0] word;
		int                sum;
		int                p;
		int                w;
		word = '0;
		word[63:60] = OP_CONV;
		word[52] = relu;
		word[50:48] = slot[2:0];
		word[31:0] = pix;
		pmem[prog_len] = word;
		prog_len++;
		// dot product over the units with the weights loaded so far.
		for (int k = 0; k < N_KERNEL; k++) begin
			sum = 0;
			for (int i = 0; i < N_CONV_UNIT; i++) begin
				p = $signed(pix[8*i +: 8]);
				w = $signed(wgt_model[i][k]);
				sum += p * w;
			end
			if (relu && sum < 0) begin
				sum = 0;
			end
			if (sum > 32767) begin
				sum = 32767;
			end else if (sum < -32768) begin
				sum = -32768;
			end
			exp_res[slot][k] = sum[15:0];
		end
	endtask

	task automatic insert_nop();
		pmem[prog_len] = {4'h7, 28'h0, 32'hffff_ffff};
		prog_len++;
	endtask

	task automatic finish_program();
		pmem[prog_len] = {OP_END, 60'h0};
		prog_len++;
	endtask

	task automatic wait_done();
		logic [31:0] status;
		status = '0;
		while (!status[1]) begin
			read_reg(REG_STATUS, status);
		end
		assert (status == 32'h2)
		else value_error($sformatf("status %h at end of run, expected 2", status));
	endtask

	task automatic check_bank();
		logic [31:0] word;
		logic [31:0] expected;
		for (int s = 0; s < N_SLOT; s++) begin
			for (int h = 0; h < 2; h++) begin
				expected = {exp_res[s][2*h+1], exp_res[s][2*h]};
				read_reg(8'(REG_RES_BASE + 8 * s + 4 * h), word);
				assert (word == expected)
				else value_error($sformatf("slot %0d word %0d read %h, expected %h",
					s, h, word, expected));
			end
		end
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] w;
		seed = 32'h3a3c7670;
		rst_i = 1'b1;
		s_axi_awaddr_i = '0;
		s_axi_awvalid_i = 1'b0;
		s_axi_wdata_i = '0;
		s_axi_wstrb_i = '0;
		s_axi_wvalid_i = 1'b0;
		s_axi_bready_i = 1'b0;
		s_axi_araddr_i = '0;
		s_axi_arvalid_i = 1'b0;
		s_axi_rready_i = 1'b0;
		pmem_do_i = '0;
		for (int u = 0; u < N_CONV_UNIT; u++) begin
			for (int k = 0; k < N_KERNEL; k++) begin
				wgt_model[u][k] = '0;
			end
		end
		for (int s = 0; s < N_SLOT; s++) begin
			for (int k = 0; k < N_KERNEL; k++) begin
				exp_res[s][k] = '0;
			end
		end
		repeat (4) @(posedge aclk);
		#1;
		rst_i = 1'b0;

		read_reg(REG_STATUS, rd);
		assert (rd == 32'h0) else value_error($sformatf("status %h after reset", rd));
		check_bank();

		// full weight load, then plain dot products.
		clear_program();
		for (int u = 0; u < N_CONV_UNIT; u++) begin
			add_weight_load(u, $random(seed));
		end
		insert_nop();
		for (int s = 0; s < 4; s++) begin
			push_conv(s, 1'b0, $random(seed));
		end
		finish_program();
		write_reg(REG_CTRL, 32'h1);
		wait_done();
		check_bank();

		// extreme values, clipping and relu.
		clear_program();
		for (int u = 0; u < N_CONV_UNIT; u++) begin
			add_weight_load(u, 32'h7f80_7f80);
		end
		push_conv(4, 1'b0, 32'h8080_8080);
		push_conv(5, 1'b1, 32'h8080_8080);
		push_conv(6, 1'b1, $random(seed));
		push_conv(7, 1'b1, $random(seed));
		finish_program();
		write_reg(REG_CTRL, 32'h1);
		wait_done();
		read_reg(REG_RES_BASE + 8'd32, rd);
		assert (rd == 32'h8000_7fff) else value_error($sformatf("clip slot read %h", rd));
		read_reg(REG_RES_BASE + 8'd40, rd);
		assert (rd == 32'h0000_7fff) else value_error($sformatf("relu slot read %h", rd));
		check_bank();

		// back to back vectors with weight reloads in between.
		clear_program();
		for (int r = 0; r < 3; r++) begin
			add_weight_load(r, $random(seed));
			for (int n = 0; n < 6; n++) begin
				push_conv(pick(N_SLOT), pick(2), $random(seed));
			end
		end
		finish_program();
		write_reg(REG_CTRL, 32'h1);
		wait_done();
		check_bank();

		// random mix of loads and vectors.
		clear_program();
		for (int n = 0; n < 48; n++) begin
			if (pick(5) == 0) begin
				add_weight_load(pick(N_CONV_UNIT), $random(seed));
			end else begin
				push_conv(pick(N_SLOT), pick(2), $random(seed));
			end
		end
		finish_program();
		write_reg(REG_CTRL, 32'h1);
		wait_done();
		check_bank();

		// a restart would redo slot 0 with the reloaded weights of unit 0.
		clear_program();
		push_conv(0, 1'b0, {24'h0, 8'(pick(255) + 1)});
		w = ~{wgt_model[0][3], wgt_model[0][2], wgt_model[0][1], wgt_model[0][0]};
		add_weight_load(0, w);
		for (int n = 0; n < 40; n++) begin
			push_conv(1 + pick(N_SLOT - 1), pick(2), $random(seed));
		end
		finish_program();
		write_reg(REG_CTRL, 32'h1);
		while (pmem_addr_o < 4) begin
			@(posedge aclk);
			#1;
		end
		write_reg(REG_CTRL, 32'h1);
		wait_done();
		check_bank();

		$display("All checks passed");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+verif
src/tpu_pkg.sv
src/axi_lite_regs.sv
src/tpu_ctrl.sv
src/conv_unit.sv
src/activation_unit.sv
src/tpu_top.sv
verif/tb_tpu.sv
